// File: hw/blank_delay.sv
// ======================================================================
// Delays blanking and colour by BLANK_DLY pixel slots
// Colour is forced to black while either delayed flag shows blanking
// Reset fills the delay line with blanking so the output starts black
// ======================================================================

module blank_delay
    import colmix_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  pix_cen,
    input  sync_t sync_in,
    input  rgb_t  rgb_in,
    output sync_t sync_out,
    output rgb_t  rgb_out
);

    sync_t sync_sr [BLANK_DLY];    // Stage 0 is the newest
    rgb_t  rgb_sr  [BLANK_DLY];

    // Blanking shift register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BLANK_DLY; i++) begin
                sync_sr[i] <= '0;       // Both flags blanking
            end
        end else if (pix_cen) begin
            sync_sr[0] <= sync_in;
            for (int i = 1; i < BLANK_DLY; i++) begin
                sync_sr[i] <= sync_sr[i-1];
            end
        end
    end

    // Colour payload follows the same enable
    always_ff @(posedge clk) begin
        if (pix_cen) begin
            rgb_sr[0] <= rgb_in;
            for (int i = 1; i < BLANK_DLY; i++) begin
                rgb_sr[i] <= rgb_sr[i-1];
            end
        end
    end

    assign sync_out = sync_sr[BLANK_DLY-1];

    // Black outside the visible area
    always_comb begin
        rgb_out = (sync_out.lhbl && sync_out.lvbl) ? rgb_sr[BLANK_DLY-1] : '0;
    end

endmodule

// File: hw/colmix.sv
// ======================================================================
// Colour mixer, two palette reads per pixel slot
// gfx_idx must hold for the whole slot starting at a pix_cen edge
// Colour of that index reaches rgb 3 pix_cen edges after the slot starts
// Blanking is delayed by BLANK_DLY edges only
// ======================================================================

module colmix
    import colmix_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             pix_cen,
    input  sync_t            sync_raw,
    input  logic [IDX_W-1:0] gfx_idx,
    input  cpu_bus_t         cpu,
    output logic [7:0]       pal_rdata,
    output rgb_t             rgb,
    output sync_t            sync_dly
);

    logic              pal_we;
    logic              pal_half;    // 1 on the first clock of a slot
    logic [PAL_AW-1:0] vid_addr;
    logic [7:0]        vid_q;
    logic [7:0]        cpu_q;
    logic [7:0]        lo_q;        // Low byte waiting for its high byte
    rgb_t              col_q;
    logic              rd_sel;      // Last edge was a CPU read
    logic [7:0]        rd_hold;

    assign pal_we   = cpu.cs & cpu.we;
    assign vid_addr = {gfx_idx, ~pal_half};  // Even byte first

    palette_ram u_ram (
        .clk       (clk),
        .cpu_addr  (cpu.addr),
        .cpu_wdata (cpu.wdata),
        .cpu_we    (pal_we),
        .cpu_rdata (cpu_q),
        .vid_addr  (vid_addr),
        .vid_rdata (vid_q)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pal_half <= 1'b0;
        end else if (pix_cen) begin
            pal_half <= 1'b1;
        end else begin
            pal_half <= ~pal_half;
        end
    end

    // Low byte is on vid_q in the second clock of the slot
    // High byte follows one clock later, then the colour is assembled
    always_ff @(posedge clk) begin
        if (!pal_half) begin
            lo_q <= vid_q;
        end
        if (pal_half) begin
            col_q <= {vid_q[6:0], lo_q};   // Bit 7 of high byte dropped
        end
    end

    // CPU read data holds until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_sel  <= 1'b0;
            rd_hold <= '0;
        end else begin
            rd_sel  <= cpu.cs & ~cpu.we;
            rd_hold <= pal_rdata;
        end
    end

    assign pal_rdata = rd_sel ? cpu_q : rd_hold;

    blank_delay u_blank (
        .clk      (clk),
        .rst      (rst),
        .pix_cen  (pix_cen),
        .sync_in  (sync_raw),
        .rgb_in   (col_q),
        .sync_out (sync_dly),
        .rgb_out  (rgb)
    );

endmodule

// File: hw/colmix_pkg.sv
// ======================================================================
// Geometry, palette sizes and bus structs shared by the colour path
// Frame is tiny on purpose so one frame simulates in a few thousand clocks
// Palette holds 128 colours of two bytes each, low byte at the even address
// ======================================================================

package colmix_pkg;

    // Palette RAM
    localparam int PAL_AW    = 8;              // Byte address width
    localparam int PAL_DEPTH = 2 ** PAL_AW;    // 256 bytes
    localparam int IDX_W     = 7;              // Colour index, one bit short of PAL_AW

    // Video geometry in pixel slots and lines
    localparam int H_TOTAL   = 64;
    localparam int H_ACTIVE  = 48;
    localparam int V_TOTAL   = 24;
    localparam int V_ACTIVE  = 16;

    // Counter widths derived from the totals
    localparam int H_CW      = $clog2(H_TOTAL);
    localparam int V_CW      = $clog2(V_TOTAL);

    // Slots of delay between raw blanking and the output
    localparam int BLANK_DLY = 2;

    // 15-bit colour, blue on top
    // Low byte gives bits 7..0, high byte bits 6..0 give bits 14..8
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb_t;

    // Active low blanking, 1 means visible
    typedef struct packed {
        logic lhbl;     // Horizontal
        logic lvbl;     // Vertical
    } sync_t;

    // CPU strobe bus, no handshake
    typedef struct packed {
        logic              cs;
        logic              we;      // 1 write, 0 read
        logic [PAL_AW-1:0] addr;
        logic [7:0]        wdata;
    } cpu_bus_t;

endpackage

// File: hw/palette_ram.sv
// ======================================================================
// Palette byte RAM, CPU read/write port and video read-only port
// Both read ports are registered, data one clock after the address
// Read during write returns old data on both ports
// Contents are undefined until written
// ======================================================================

module palette_ram
    import colmix_pkg::*;
(
    input  logic              clk,
    // CPU side
    input  logic [PAL_AW-1:0] cpu_addr,
    input  logic [7:0]        cpu_wdata,
    input  logic              cpu_we,
    output logic [7:0]        cpu_rdata,
    // Video side
    input  logic [PAL_AW-1:0] vid_addr,
    output logic [7:0]        vid_rdata
);

    logic [7:0] mem [PAL_DEPTH];

    // Single write port, both reads use nonblocking so they see old data
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        cpu_rdata <= mem[cpu_addr];     // Reads every clock
        vid_rdata <= mem[vid_addr];
    end

endmodule

// File: hw/video_colour_top.sv
// ======================================================================
// Colour output stage with its own timing generator
// One clock and one synchronous reset for CPU and video
// pix_cen is exported so stimulus can follow the pixel slots
// No latency beyond the timing generator and the colour mixer
// ======================================================================

module video_colour_top
    import colmix_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    // CPU palette access
    input  cpu_bus_t         cpu,
    output logic [7:0]       pal_rdata,
    // Graphics layer colour index
    input  logic [IDX_W-1:0] gfx_idx,
    // Video out
    output logic             pix_cen,
    output rgb_t             rgb,
    output sync_t            sync_dly
);

    sync_t sync_raw;    // Undelayed blanking from the counters

    video_timing u_timing (
        .clk     (clk),
        .rst     (rst),
        .pix_cen (pix_cen),
        .sync    (sync_raw)
    );

    colmix u_colmix (
        .clk       (clk),
        .rst       (rst),
        .pix_cen   (pix_cen),
        .sync_raw  (sync_raw),
        .gfx_idx   (gfx_idx),
        .cpu       (cpu),
        .pal_rdata (pal_rdata),
        .rgb       (rgb),
        .sync_dly  (sync_dly)
    );

endmodule

// File: hw/video_timing.sv
// ======================================================================
// Pixel clock enable and raw blanking for the colour path
// pix_cen runs at half the clk rate and is high on the first clock
// after reset; counters and blanking only move on pix_cen
// Blanking flags are registered and change together with the counters
// ======================================================================

module video_timing
    import colmix_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    output logic  pix_cen,
    output sync_t sync
);

    logic [H_CW-1:0] h_cnt;     // Pixel slot in line
    logic [V_CW-1:0] v_cnt;     // Line in frame
    logic [H_CW-1:0] h_nxt;
    logic [V_CW-1:0] v_nxt;
    logic            h_wrap;
    logic            v_wrap;

    // Next counter values, used for both the counters and the flags
    always_comb begin
        h_wrap = h_cnt == H_CW'(H_TOTAL - 1);
        v_wrap = v_cnt == V_CW'(V_TOTAL - 1);
        h_nxt  = h_wrap ? '0 : h_cnt + 1'b1;
        v_nxt  = v_cnt;
        if (h_wrap) begin
            // Line advances only at end of line
            v_nxt = v_wrap ? '0 : v_cnt + 1'b1;
        end
    end

    // Half rate enable
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_cen <= 1'b1;    // First clock out of reset is an enable
        end else begin
            pix_cen <= ~pix_cen;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            sync.lhbl <= 1'b1;  // Counter 0 is inside the visible area
            sync.lvbl <= 1'b1;
        end else if (pix_cen) begin
            h_cnt     <= h_nxt;
            v_cnt     <= v_nxt;
            // Compare the next values so flags match the counters
            sync.lhbl <= h_nxt < H_CW'(H_ACTIVE);
            sync.lvbl <= v_nxt < V_CW'(V_ACTIVE);
        end
    end

endmodule

// File: project.f
hw/colmix_pkg.sv
hw/video_timing.sv
hw/palette_ram.sv
hw/blank_delay.sv
hw/colmix.sv
hw/video_colour_top.sv
testbench/colmix_properties.sv
testbench/tb_video_colour.sv

// File: run.sh
#!/bin/sh
# Build and run the colour stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_video_colour -f project.f \
        --Mdir obj_dir -o sim_video_colour; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_video_colour > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

// File: testbench/colmix_properties.sv
// ======================================================================
// Concurrent checks bound into every colmix instance
// Checks are held off during reset and the read data check one clock more
// ======================================================================

module colmix_properties
    import colmix_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       pix_cen,
    input cpu_bus_t   cpu,
    input logic [7:0] pal_rdata,
    input rgb_t       rgb,
    input sync_t      sync_dly
);

    // Enable is half rate and never high twice in a row
    a_cen_half: assert property (@(posedge clk) (!rst && pix_cen) |=> !pix_cen)
        else $error("pix_cen high on two consecutive clocks");

    // Black outside the visible area
    a_blank_black: assert property (@(posedge clk)
        !(sync_dly.lhbl && sync_dly.lvbl) |-> rgb == '0)
        else $error("rgb not black during blanking");

    // Read data only moves after a CPU read
    a_rdata_hold: assert property (@(posedge clk)
        (!rst && !$past(rst) && !$past(cpu.cs)) |-> $stable(pal_rdata))
        else $error("pal_rdata changed without a CPU read");

endmodule

bind colmix colmix_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .pix_cen   (pix_cen),
    .cpu       (cpu),
    .pal_rdata (pal_rdata),
    .rgb       (rgb),
    .sync_dly  (sync_dly)
);

// File: testbench/tb_video_colour.sv
// ======================================================================
// Testbench for video_colour_top against a palette model
// Reference colour is computed when a slot ends, so CPU writes that
// touch a visible colour must sit inside blanking (test 5 does this)
// Inputs change on the falling edge
// The model steps on pix_cen edges
// ======================================================================

module tb_video_colour
    import colmix_pkg::*;
;

    localparam int FRAME_CLKS    = H_TOTAL * V_TOTAL * 2;   // 2 clocks per slot
    localparam int TEST_FRAMES   = 5;                        // Tests 2..6 together
    localparam int MARGIN_FRAMES = 3;
    localparam int FIX_IDX       = 9;                        // Entry rewritten in test 5
    localparam int HI7_IDX       = 5;                        // High byte with bit 7 set

    logic             clk;
    logic             rst;
    cpu_bus_t         cpu;
    logic [IDX_W-1:0] gfx_idx;
    logic [7:0]       pal_rdata;
    logic             pix_cen;
    rgb_t             rgb;
    sync_t            sync_dly;

    logic [7:0] shadow [PAL_DEPTH];     // Palette model
    integer     seed = 30470;
    int         err_cnt, chk_cnt, vis_chk, blank_chk, tests_run, tests_ok;
    logic       chk_rgb;                // Visible colour checks armed
    logic       cen_seen;               // pix_cen as seen at the last negedge
    int         m_h, m_v;               // Counter model
    sync_t      raw_cur, raw_d1, raw_d2;
    rgb_t       c1, c2, c3;             // Colour history with c3 due at the output
    sync_t      exp_sync;
    rgb_t       exp_rgb;
    logic       exp_valid;

    video_colour_top u_video_colour_top (
        .clk       (clk),
        .rst       (rst),
        .cpu       (cpu),
        .pal_rdata (pal_rdata),
        .gfx_idx   (gfx_idx),
        .pix_cen   (pix_cen),
        .rgb       (rgb),
        .sync_dly  (sync_dly)
    );

    always #5 clk = ~clk;

    // Low byte at 2k and high byte at 2k+1 with its bit 7 unused
    function automatic rgb_t ref_colour(input logic [IDX_W-1:0] idx);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = shadow[{idx, 1'b0}];
        hi = shadow[{idx, 1'b1}];
        return {hi[6:0], lo};
    endfunction

    // Model steps on each pix_cen edge and is compared at the next negedge
    always @(posedge clk) begin
        if (rst) begin
            m_h       = 0;
            m_v       = 0;
            raw_cur   = 2'b11;      // Counter 0 is visible
            raw_d1    = '0;
            raw_d2    = '0;
            c1        = '0;
            c2        = '0;
            c3        = '0;
            exp_valid = 1'b0;
        end else if (cen_seen) begin
            c3 = c2;
            c2 = c1;
            c1 = ref_colour(gfx_idx);   // Index of the slot just ended
            raw_d2 = raw_d1;
            raw_d1 = raw_cur;
            if (m_h == H_TOTAL - 1) begin
                m_h = 0;
                m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
            end else begin
                m_h = m_h + 1;
            end
            raw_cur.lhbl = m_h < H_ACTIVE;
            raw_cur.lvbl = m_v < V_ACTIVE;
            exp_sync  = raw_d2;
            exp_rgb   = c3;             // Only used for visible slots
            exp_valid = 1'b1;
        end
    end

    // Compare process
    always @(negedge clk) begin
        cen_seen = pix_cen;
        if (exp_valid) begin
            exp_valid = 1'b0;
            chk_cnt++;
            if (sync_dly !== exp_sync) begin
                err_cnt++;
                $display("[FAIL] sync_dly expected 0x%h got 0x%h at %0t", exp_sync, sync_dly,
                         $time);
            end
            if (!(exp_sync.lhbl && exp_sync.lvbl)) begin
                blank_chk++;
                if (rgb !== '0) begin
                    err_cnt++;
                    $display("[FAIL] rgb expected 0x0000 got 0x%h at %0t", rgb, $time);
                end
            end else if (chk_rgb) begin
                vis_chk++;
                if (rgb !== exp_rgb) begin
                    err_cnt++;
                    $display("[FAIL] rgb expected 0x%h got 0x%h at %0t", exp_rgb, rgb, $time);
                end
            end
        end
    end

    // Waits for the falling edge that starts a slot
    task automatic next_slot();
        do begin
            @(negedge clk);
        end while (pix_cen !== 1'b0);
    endtask

    task automatic write_byte(input int addr, input logic [7:0] data);
        @(negedge clk);
        cpu.cs    = 1'b1;
        cpu.we    = 1'b1;
        cpu.addr  = addr[PAL_AW-1:0];
        cpu.wdata = data;
        shadow[addr] = data;
    endtask

    task automatic release_bus();
        @(negedge clk);
        cpu = '0;
    endtask

    task automatic drive_random_idx();
        int r;
        r = $random(seed);
        gfx_idx = r[IDX_W-1:0];
    endtask

    task automatic report_test(input string name, input int err0, input logic extra_ok);
        tests_run++;
        if (err_cnt == err0 && extra_ok) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    task automatic verify_reset();
        int   err0;
        logic prev;
        err0 = err_cnt;
        if (sync_dly !== '0) begin
            err_cnt++;
            $display("[FAIL] sync_dly expected 0x0 got 0x%h", sync_dly);
        end
        if (rgb !== '0) begin
            err_cnt++;
            $display("[FAIL] rgb expected 0x0000 got 0x%h", rgb);
        end
        if (pal_rdata !== 8'h00) begin
            err_cnt++;
            $display("[FAIL] pal_rdata expected 0x00 got 0x%h", pal_rdata);
        end
        if (pix_cen !== 1'b1) begin     // First clock out of reset is an enable
            err_cnt++;
            $display("[FAIL] pix_cen expected 0x1 got 0x%h", pix_cen);
        end
        prev = pix_cen;
        repeat (6) begin
            @(negedge clk);
            if (pix_cen === prev) begin
                err_cnt++;
                $display("pix_cen did not alternate after reset at %0t", $time);
            end
            prev = pix_cen;
        end
        report_test("reset state", err0, 1'b1);
    endtask

    task automatic exercise_cpu_port();
        int         err0;
        int         r;
        logic [7:0] d;
        err0 = err_cnt;
        for (int a = 0; a < PAL_DEPTH; a++) begin
            r = $random(seed);
            d = r[7:0];
            if (a == 2 * HI7_IDX + 1) d[7] = 1'b1;     // Must be ignored later
            write_byte(a, d);
        end
        for (int a = 0; a <= PAL_DEPTH; a++) begin
            @(negedge clk);
            if (a > 0 && pal_rdata !== shadow[a-1]) begin
                err_cnt++;
                $display("[FAIL] pal_rdata addr 0x%h expected 0x%h got 0x%h", a - 1,
                         shadow[a-1], pal_rdata);
            end
            cpu.cs   = (a < PAL_DEPTH);
            cpu.we   = 1'b0;
            cpu.addr = a[PAL_AW-1:0];
        end
        release_bus();
        report_test("cpu access", err0, 1'b1);
    endtask

    task automatic sweep_random_lookup();
        int err0;
        int vis0;
        err0 = err_cnt;
        vis0 = vis_chk;
        repeat (4) begin
            next_slot();
            drive_random_idx();
        end
        chk_rgb = 1'b1;     // History now holds only written entries
        for (int s = 0; s < H_TOTAL * V_TOTAL; s++) begin
            next_slot();
            if (s % 7 == 3) gfx_idx = IDX_W'(HI7_IDX);
            else drive_random_idx();
        end
        if (vis_chk == vis0) begin
            err_cnt++;
            $display("No visible pixel was compared during the colour lookup test");
        end
        report_test("colour lookup", err0, 1'b1);
    endtask

    task automatic scan_blanking_frame();
        int err0;
        int blk0;
        err0 = err_cnt;
        blk0 = blank_chk;
        for (int s = 0; s < H_TOTAL * V_TOTAL; s++) begin
            next_slot();
            drive_random_idx();
        end
        report_test("blanking alignment", err0, blank_chk > blk0);
    endtask

    task automatic update_palette_live();
        int   err0;
        int   hits;
        rgb_t new_col;
        err0 = err_cnt;
        hits = 0;
        next_slot();
        gfx_idx = IDX_W'(FIX_IDX);
        do begin
            next_slot();
        end while (!(m_h == 52 && m_v >= 1 && m_v < V_ACTIVE - 2));
        // Inside horizontal blanking of a visible line
        write_byte(2 * FIX_IDX, shadow[2*FIX_IDX] ^ 8'h5a);
        write_byte(2 * FIX_IDX + 1, shadow[2*FIX_IDX+1] ^ 8'h25);
        release_bus();
        new_col = ref_colour(IDX_W'(FIX_IDX));
        repeat (2 * H_TOTAL) begin
            next_slot();
            if (sync_dly.lhbl && sync_dly.lvbl && rgb === new_col) hits++;
        end
        if (hits < H_ACTIVE) begin
            err_cnt++;
            $display("New colour shown on only %0d pixels after the palette update", hits);
        end
        report_test("live palette update", err0, 1'b1);
    endtask

    task automatic measure_line();
        int   err0;
        int   n;
        int   vis;
        logic prev;
        err0 = err_cnt;
        n    = 0;
        vis  = 0;
        do begin                        // Find start of horizontal blanking
            prev = sync_dly.lhbl;
            next_slot();
        end while (!(prev && !sync_dly.lhbl));
        do begin
            prev = sync_dly.lhbl;
            next_slot();
            n++;
            if (sync_dly.lhbl) vis++;
        end while (!(prev && !sync_dly.lhbl));
        if (n != H_TOTAL) begin
            err_cnt++;
            $display("[FAIL] sync_dly.lhbl period expected 0x%h got 0x%h", H_TOTAL, n);
        end
        if (vis != H_ACTIVE) begin
            err_cnt++;
            $display("[FAIL] sync_dly.lhbl visible run expected 0x%h got 0x%h", H_ACTIVE, vis);
        end
        report_test("frame geometry", err0, 1'b1);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cpu       = '0;
        gfx_idx   = '0;
        chk_rgb   = 1'b0;
        cen_seen  = 1'b0;
        exp_valid = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        verify_reset();
        exercise_cpu_port();
        sweep_random_lookup();
        scan_blanking_frame();
        update_palette_live();
        measure_line();
        $display("tests %0d, passed %0d, checks %0d, errors %0d", tests_run, tests_ok,
                 chk_cnt, err_cnt);
        if (err_cnt == 0 && tests_ok == tests_run) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((TEST_FRAMES + MARGIN_FRAMES) * FRAME_CLKS * 10);
        $display("Timeout: run did not finish within %0d frames",
                 TEST_FRAMES + MARGIN_FRAMES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
